//--- dv/mem_model.sv
// main-memory model for the cache testbench: line-wide port, random 1 to 8 cycle response, known fill
`timescale 1ns/1ps

module mem_model #(
	parameter int          LINE_COUNT = 128,           // lines backed by the model
	parameter logic [31:0] INIT_XOR   = 32'h0000_0000  // fill pattern is word address xor this
) (
	input  logic                             clk,
	input  logic                             pmem_read,
	input  logic                             pmem_write,
	input  logic [cache_pkg::ADDR_BITS-1:0]  pmem_address,
	input  logic [cache_pkg::LINE_BITS-1:0]  pmem_wdata,
	output logic [cache_pkg::LINE_BITS-1:0]  pmem_rdata,
	output logic                             pmem_resp
);

	localparam int LINE_IDX_BITS = $clog2(LINE_COUNT);

	logic [cache_pkg::LINE_BITS-1:0] lines [LINE_COUNT];
	logic [cache_pkg::LINE_BITS-1:0] rdata_q  = '0;
	logic                            resp_q   = 1'b0;
	logic                            busy     = 1'b0;  // request seen, delay running
	logic                            loaded   = 1'b0;  // fill pattern written
	int unsigned                     wait_cnt = 0;
	logic [LINE_IDX_BITS-1:0]        line_idx;

	assign line_idx   = pmem_address[cache_pkg::OFFSET_BITS +: LINE_IDX_BITS];
	assign pmem_rdata = rdata_q;
	assign pmem_resp  = resp_q;

	// works on the falling edge so the cache sees stable data at its rising edge
	always @(negedge clk) begin
		if (!loaded) begin
			for (int l = 0; l < LINE_COUNT; l++)
				for (int w = 0; w < 8; w++)
					lines[l][w*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS] = 32'(l * 8 + w) ^ INIT_XOR;
			loaded = 1'b1;
		end
		if (resp_q) begin
			resp_q = 1'b0;  // resp is a one cycle pulse
		end else if (pmem_read || pmem_write) begin
			if (!busy) begin
				busy     = 1'b1;
				wait_cnt = $urandom_range(7, 0);
			end
			if (wait_cnt == 0) begin
				if (pmem_write)
					lines[line_idx] = pmem_wdata;  // keep written lines
				else
					rdata_q = lines[line_idx];
				resp_q = 1'b1;
				busy   = 1'b0;
			end else begin
				wait_cnt = wait_cnt - 1;
			end
		end
	end

endmodule : mem_model

//--- dv/tb_cache.sv
// testbench for the two-way cache: directed and random cpu traffic checked against a shadow memory
`timescale 1ns/1ps

module tb_cache;

	localparam int          SET_BITS       = 3;
	localparam int          WORDS          = 1024;  // 4 KiB address space under test
	localparam int          TIMEOUT_CYCLES = 20000; // 400 random ops at 25 cycles plus directed
	localparam logic [31:0] INIT_XOR       = 32'hc0de_0000;

	logic        clk             = 1'b0;
	logic        rst             = 1'b1;
	logic        mem_read        = 1'b0;
	logic        mem_write       = 1'b0;
	logic [31:0] mem_address     = '0;
	logic [31:0] mem_wdata       = '0;
	logic [3:0]  mem_byte_enable = '0;
	logic [31:0] mem_rdata;
	logic        mem_resp;
	logic        pmem_read, pmem_write, pmem_resp;
	logic [31:0] pmem_address;
	logic [255:0] pmem_wdata, pmem_rdata;

	logic [31:0]  shadow [WORDS];  // expected memory image, word granular
	logic [31:0]  exp_word;
	logic [255:0] exp_line;
	logic         resp_q, started;
	logic [31:0]  rdata_q, wb_addr;
	int           rd_count, wr_count;
	int           cycle_count = 0;

	cache_top #(.SET_BITS(SET_BITS)) UUT (
		.clk, .rst, .mem_read, .mem_write, .mem_address, .mem_wdata, .mem_byte_enable,
		.mem_rdata, .mem_resp, .pmem_read, .pmem_write, .pmem_address, .pmem_wdata,
		.pmem_rdata, .pmem_resp
	);

	mem_model #(.LINE_COUNT(WORDS / 8), .INIT_XOR(INIT_XOR)) memory (
		.clk, .pmem_read, .pmem_write, .pmem_address, .pmem_wdata, .pmem_rdata, .pmem_resp
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] word_pattern(input logic [31:0] widx);
		return widx ^ INIT_XOR;  // initial memory contents
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] be);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (be[b])
				res[b*8 +: 8] = data[b*8 +: 8];
		return res;
	endfunction

	function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
		return (32'(tag) << (SET_BITS + cache_pkg::OFFSET_BITS)) |
			(32'(set) << cache_pkg::OFFSET_BITS) | (32'(word) << 2);
	endfunction

	task automatic stop_with_failure;
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// one cpu request, called on a falling edge, returns on the falling edge after mem_resp
	task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] be, output logic [31:0] rdata, output int cycles);
		mem_read        = ~wr;
		mem_write       = wr;
		mem_address     = addr;
		mem_wdata       = data;
		mem_byte_enable = be;
		cycles          = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!resp_q);
		mem_read  = 1'b0;
		mem_write = 1'b0;
		rdata     = rdata_q;
	endtask

	// bookkeeping at the rising edge, all from pre-edge values
	always @(posedge clk) begin
		resp_q  <= mem_resp;
		rdata_q <= mem_rdata;
		if (rst) begin
			started  <= 1'b0;
			rd_count <= 0;
			wr_count <= 0;
			for (int i = 0; i < WORDS; i++)
				shadow[i] <= word_pattern(i);
		end else begin
			if (mem_read || mem_write)
				started <= 1'b1;
			if (pmem_resp && pmem_read)
				rd_count <= rd_count + 1;
			if (pmem_resp && pmem_write) begin
				wr_count <= wr_count + 1;
				wb_addr  <= pmem_address;
			end
			if (mem_resp && mem_write)
				shadow[mem_address[11:2]] <= merge_bytes(shadow[mem_address[11:2]], mem_wdata,
					mem_byte_enable);
		end
	end

	assign exp_word = shadow[mem_address[11:2]];

	always_comb begin
		for (int w = 0; w < 8; w++)
			exp_line[w*32 +: 32] = shadow[{pmem_address[11:5], 3'(w)}];
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	a_reset_quiet: assert property (@(posedge clk) disable iff (rst)
		started || (!mem_resp && !pmem_read && !pmem_write))
		else begin
			$display("Cache became active after reset before any request");
			stop_with_failure();
		end

	a_one_op: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
		else begin
			$display("mem_read and mem_write are high together");
			stop_with_failure();
		end

	a_rdata: assert property (@(posedge clk) disable iff (rst)
		!(mem_resp && mem_read) || (mem_rdata == exp_word))
		else begin
			$display("Error: mem_rdata = 0x%08h, expected 0x%08h", mem_rdata, exp_word);
			stop_with_failure();
		end

	a_wb_line: assert property (@(posedge clk) disable iff (rst)
		!(pmem_resp && pmem_write) || (pmem_wdata == exp_line))
		else begin
			$display("Error: pmem_wdata = 0x%064h, expected 0x%064h", pmem_wdata, exp_line);
			stop_with_failure();
		end

	initial begin
		logic [31:0] rdata, data, expected, a_addr, b_addr, c_addr;
		logic [3:0]  be_list [5];
		int          cycles, reads_before, writes_before;
		be_list = '{4'b0001, 4'b0110, 4'b1000, 4'b0000, 4'b1111};
		void'($urandom(54));
		repeat (4) @(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk);  // idle time for the post-reset check

		// read miss then hit in set 0
		a_addr       = make_addr(1, 0, 3);
		reads_before = rd_count;
		access(1'b0, a_addr, '0, '0, rdata, cycles);
		expect_word("pmem_read count", rd_count - reads_before, 1);
		expect_word("mem_rdata", rdata, word_pattern(a_addr >> 2));
		reads_before = rd_count;
		access(1'b0, a_addr, '0, '0, rdata, cycles);
		expect_word("hit latency", cycles, 1);
		expect_word("pmem_read count", rd_count - reads_before, 0);

		// byte enable merges on one word of set 3
		a_addr   = make_addr(1, 3, 5);
		expected = word_pattern(a_addr >> 2);
		for (int i = 0; i < 5; i++) begin
			data     = $urandom();
			access(1'b1, a_addr, data, be_list[i], rdata, cycles);
			expected = merge_bytes(expected, data, be_list[i]);
			access(1'b0, a_addr, '0, '0, rdata, cycles);
			expect_word("mem_rdata", rdata, expected);
		end

		// dirty eviction in set 1, a written, then b and c push it out
		a_addr = make_addr(1, 1, 2);
		b_addr = make_addr(2, 1, 0);
		c_addr = make_addr(3, 1, 7);
		data   = $urandom();
		access(1'b1, a_addr, data, 4'b1111, rdata, cycles);
		writes_before = wr_count;
		access(1'b0, b_addr, '0, '0, rdata, cycles);
		expect_word("pmem_write count", wr_count - writes_before, 0);
		access(1'b0, c_addr, '0, '0, rdata, cycles);
		expect_word("pmem_write count", wr_count - writes_before, 1);
		expect_word("pmem_address", wb_addr, {a_addr[31:5], 5'b0});
		writes_before = wr_count;
		access(1'b0, a_addr, '0, '0, rdata, cycles);  // victim b is clean
		expect_word("pmem_write count", wr_count - writes_before, 0);
		expect_word("mem_rdata", rdata, data);

		// lru in set 2, a b a c leaves a and c
		a_addr = make_addr(1, 2, 0);
		b_addr = make_addr(2, 2, 0);
		c_addr = make_addr(3, 2, 0);
		access(1'b0, a_addr, '0, '0, rdata, cycles);
		access(1'b0, b_addr, '0, '0, rdata, cycles);
		access(1'b0, a_addr, '0, '0, rdata, cycles);
		access(1'b0, c_addr, '0, '0, rdata, cycles);
		reads_before = rd_count;
		access(1'b0, a_addr, '0, '0, rdata, cycles);
		expect_word("hit latency", cycles, 1);
		expect_word("pmem_read count", rd_count - reads_before, 0);
		access(1'b0, b_addr, '0, '0, rdata, cycles);
		expect_word("pmem_read count", rd_count - reads_before, 1);

		// random traffic over sets 4 to 7 and four tags
		for (int n = 0; n < 400; n++) begin
			a_addr = make_addr($urandom_range(3, 0), $urandom_range(7, 4), $urandom_range(7, 0));
			access(1'($urandom_range(1, 0)), a_addr, $urandom(), 4'($urandom()), rdata, cycles);
		end

		repeat (2) @(negedge clk);
		$display("Everything OK");
		$finish;
	end

endmodule : tb_cache

//--- flist.f
hw/cache_pkg.sv
hw/cache_way.sv
hw/cache_datapath.sv
hw/cache_control.sv
hw/cache_top.sv
dv/mem_model.sv
dv/tb_cache.sv

//--- hw/cache_control.sv
// cache controller FSM: answers hits in idle, sequences write-back, fetch, fill and respond on a miss
`timescale 1ns/1ps

module cache_control (
	input  logic clk,
	input  logic rst,

	// cpu side
	input  logic mem_read,
	input  logic mem_write,
	output logic mem_resp,

	// from datapath
	input  logic cache_hit,
	input  logic dirty_o,  // victim is dirty
	input  logic lru_out,  // victim way
	input  logic hit1,

	// to datapath
	output logic way_sel,
	output logic tag_sel,
	output logic source_sel,
	output logic load_cache,
	output logic load_lru,

	// memory side
	input  logic pmem_resp,
	output logic pmem_read,
	output logic pmem_write
);

	typedef enum logic [2:0] {
		s_idle,
		s_write_back,
		s_fetch,
		s_fill,
		s_respond
	} state_t;

	state_t state, next_state;
	logic   req;  // cpu has a request up

	assign req = mem_read | mem_write;

	// output decode
	always_comb begin
		way_sel    = hit1;  // idle hits access the hitting way
		tag_sel    = 1'b1;  // cpu tag forms the memory address
		source_sel = 1'b0;
		load_cache = 1'b0;
		load_lru   = 1'b0;
		mem_resp   = 1'b0;
		pmem_read  = 1'b0;
		pmem_write = 1'b0;

		case (state)
			s_idle: begin
				if (req & cache_hit) begin
					mem_resp   = 1'b1;      // zero-wait hit
					load_lru   = 1'b1;
					load_cache = mem_write; // write hit merges word and sets dirty
				end
			end

			s_write_back: begin
				way_sel    = lru_out;
				tag_sel    = 1'b0;  // address of the victim line
				pmem_write = 1'b1;
			end

			s_fetch: begin
				way_sel    = lru_out;
				pmem_read  = 1'b1;
				source_sel = 1'b1;       // store the memory line
				load_cache = pmem_resp;  // data only valid in the resp cycle
			end

			s_fill: begin
				way_sel    = lru_out;
				load_cache = mem_write;  // write miss merges into the fresh line
			end

			s_respond: begin
				way_sel  = lru_out;  // the line now sits in the old victim way
				mem_resp = 1'b1;
				load_lru = 1'b1;
			end

			default: begin
			end
		endcase
	end

	// next state
	always_comb begin
		next_state = state;
		case (state)
			s_idle: begin
				if (req & ~cache_hit)
					next_state = dirty_o ? s_write_back : s_fetch;
			end

			s_write_back: begin
				if (pmem_resp)
					next_state = s_fetch;  // then continue like a clean miss
			end

			s_fetch: begin
				if (pmem_resp)
					next_state = s_fill;
			end

			s_fill:    next_state = s_respond;
			s_respond: next_state = s_idle;
			default:   next_state = s_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= s_idle;
		else
			state <= next_state;
	end

endmodule : cache_control

//--- hw/cache_datapath.sv
// cache datapath: two ways, lru bits, hit combine, word merge and port muxes, steered by cache_control
`timescale 1ns/1ps

module cache_datapath #(
	parameter int SET_BITS = 3
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [cache_pkg::ADDR_BITS-1:0]  mem_address,
	input  logic [cache_pkg::WORD_BITS-1:0]  mem_wdata,
	input  logic [cache_pkg::BE_BITS-1:0]    mem_byte_enable,
	input  logic [cache_pkg::LINE_BITS-1:0]  pmem_rdata,
	input  logic                             way_sel,     // 0 way0, 1 way1
	input  logic                             tag_sel,     // 1 cpu tag, 0 stored tag
	input  logic                             source_sel,  // 0 cpu merge, 1 memory line
	input  logic                             load_cache,
	input  logic                             load_lru,
	output logic [cache_pkg::WORD_BITS-1:0]  mem_rdata,
	output logic [cache_pkg::ADDR_BITS-1:0]  pmem_address,
	output logic [cache_pkg::LINE_BITS-1:0]  pmem_wdata,
	output logic                             cache_hit,
	output logic                             hit1,
	output logic                             lru_out,
	output logic                             dirty_o
);

	localparam int TAG_BITS  = cache_pkg::ADDR_BITS - SET_BITS - cache_pkg::OFFSET_BITS;
	localparam int NUM_SETS  = 2 ** SET_BITS;
	localparam int BYTE_BITS = $clog2(cache_pkg::BE_BITS); // byte offset within a word

	logic [SET_BITS-1:0]                  index;
	logic [TAG_BITS-1:0]                  cpu_tag;
	logic [cache_pkg::OFFSET_BITS-BYTE_BITS-1:0] word_idx;  // word within the line
	logic                                 hit0;
	logic                                 valid0, valid1;
	logic                                 dirty0, dirty1;
	logic [TAG_BITS-1:0]                  tag0, tag1;
	logic [cache_pkg::LINE_BITS-1:0]      line0, line1;
	logic [cache_pkg::LINE_BITS-1:0]      sel_line;   // line of the way picked by control
	logic [cache_pkg::LINE_BITS-1:0]      hit_line;
	logic [cache_pkg::LINE_BITS-1:0]      merged_line;
	logic [cache_pkg::LINE_BITS-1:0]      new_line;   // what gets stored on load_cache
	logic [TAG_BITS-1:0]                  sel_tag;
	logic [NUM_SETS-1:0]                  lru_q;      // per set, way not used last

	// split the cpu address
	assign index    = mem_address[cache_pkg::OFFSET_BITS +: SET_BITS];
	assign cpu_tag  = mem_address[cache_pkg::ADDR_BITS-1 -: TAG_BITS];
	assign word_idx = mem_address[cache_pkg::OFFSET_BITS-1:BYTE_BITS];

	cache_way #(.SET_BITS(SET_BITS)) way0 (
		.clk, .rst, .index, .tag(cpu_tag),
		.load(load_cache & ~way_sel), // only the selected way is written
		.line_in(new_line), .dirty_in(~source_sel),
		.hit(hit0), .valid(valid0), .dirty(dirty0), .tag_out(tag0), .line_out(line0)
	);

	cache_way #(.SET_BITS(SET_BITS)) way1 (
		.clk, .rst, .index, .tag(cpu_tag),
		.load(load_cache & way_sel),
		.line_in(new_line), .dirty_in(~source_sel),
		.hit(hit1), .valid(valid1), .dirty(dirty1), .tag_out(tag1), .line_out(line1)
	);

	assign cache_hit = hit0 | hit1;
	assign hit_line  = hit1 ? line1 : line0;
	assign mem_rdata = hit_line[word_idx*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS];

	assign sel_line = way_sel ? line1 : line0;
	assign sel_tag  = way_sel ? tag1 : tag0;

	// drop the cpu word into the selected line under the byte enables
	always_comb begin
		merged_line = sel_line;
		for (int b = 0; b < cache_pkg::BE_BITS; b++) begin
			if (mem_byte_enable[b])
				merged_line[word_idx*cache_pkg::WORD_BITS + b*8 +: 8] = mem_wdata[b*8 +: 8];
		end
	end

	assign new_line = source_sel ? pmem_rdata : merged_line;

	// lru points at the other way after each access
	always_ff @(posedge clk) begin
		if (rst)
			lru_q <= '0;
		else if (load_lru)
			lru_q[index] <= ~way_sel;
	end

	assign lru_out = lru_q[index];
	assign dirty_o = lru_out ? (valid1 & dirty1) : (valid0 & dirty0); // victim needs write-back

	// line aligned, victim tag during write-back
	assign pmem_address = {tag_sel ? cpu_tag : sel_tag, index, {cache_pkg::OFFSET_BITS{1'b0}}};
	assign pmem_wdata   = sel_line;

endmodule : cache_datapath

//--- hw/cache_pkg.sv
// shared address, word and line sizes for the two-way cache; referenced by scoped name from rtl and dv
package cache_pkg;

	// cpu and memory byte address
	localparam int ADDR_BITS = 32;

	// one cpu data word
	localparam int WORD_BITS = 32;

	// one cache line, 8 words
	localparam int LINE_BITS = 256;

	// byte offset within a line
	localparam int OFFSET_BITS = 5;

	// cpu byte enable, one bit per byte of a word
	localparam int BE_BITS = 4;

endpackage : cache_pkg

//--- hw/cache_top.sv
// top of the two-way write-back cache; connects control and datapath between cpu and memory ports
`timescale 1ns/1ps

module cache_top #(
	parameter int SET_BITS = 3  // 8 sets by default
) (
	input  logic                             clk,
	input  logic                             rst,

	// cpu port
	input  logic                             mem_read,
	input  logic                             mem_write,
	input  logic [cache_pkg::ADDR_BITS-1:0]  mem_address,
	input  logic [cache_pkg::WORD_BITS-1:0]  mem_wdata,
	input  logic [cache_pkg::BE_BITS-1:0]    mem_byte_enable,
	output logic [cache_pkg::WORD_BITS-1:0]  mem_rdata,
	output logic                             mem_resp,

	// memory port, whole lines
	output logic                             pmem_read,
	output logic                             pmem_write,
	output logic [cache_pkg::ADDR_BITS-1:0]  pmem_address,
	output logic [cache_pkg::LINE_BITS-1:0]  pmem_wdata,
	input  logic [cache_pkg::LINE_BITS-1:0]  pmem_rdata,
	input  logic                             pmem_resp
);

	// control to datapath
	logic way_sel;
	logic tag_sel;
	logic source_sel;
	logic load_cache;
	logic load_lru;

	// datapath to control
	logic cache_hit;
	logic hit1;
	logic lru_out;
	logic dirty_o;

	cache_control control (
		.clk, .rst,
		.mem_read, .mem_write, .mem_resp,
		.cache_hit, .dirty_o, .lru_out, .hit1,
		.way_sel, .tag_sel, .source_sel, .load_cache, .load_lru,
		.pmem_resp, .pmem_read, .pmem_write
	);

	cache_datapath #(.SET_BITS(SET_BITS)) datapath (
		.clk, .rst,
		.mem_address, .mem_wdata, .mem_byte_enable, .pmem_rdata,
		.way_sel, .tag_sel, .source_sel, .load_cache, .load_lru,
		.mem_rdata, .pmem_address, .pmem_wdata,
		.cache_hit, .hit1, .lru_out, .dirty_o
	);

endmodule : cache_top

//--- hw/cache_way.sv
// one way of the cache: per-set valid, dirty, tag and line storage plus tag compare, used by the datapath
`timescale 1ns/1ps

module cache_way #(
	parameter int SET_BITS = 3,
	localparam int TAG_BITS = cache_pkg::ADDR_BITS - SET_BITS - cache_pkg::OFFSET_BITS
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [SET_BITS-1:0]            index,    // set being accessed
	input  logic [TAG_BITS-1:0]            tag,      // incoming cpu tag
	input  logic                           load,     // write every field of the indexed set
	input  logic [cache_pkg::LINE_BITS-1:0] line_in,
	input  logic                           dirty_in,
	output logic                           hit,
	output logic                           valid,
	output logic                           dirty,
	output logic [TAG_BITS-1:0]            tag_out,
	output logic [cache_pkg::LINE_BITS-1:0] line_out
);

	localparam int NUM_SETS = 2 ** SET_BITS;

	logic [NUM_SETS-1:0]              valid_q;   // one valid bit per set
	logic [NUM_SETS-1:0]              dirty_q;   // one dirty bit per set
	logic [TAG_BITS-1:0]              tag_q [NUM_SETS];
	logic [cache_pkg::LINE_BITS-1:0]  line_q [NUM_SETS];

	// control bits, cleared so no stale line looks valid or needs write-back
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (load) begin
			valid_q[index] <= 1'b1;     // any load leaves the set holding a real line
			dirty_q[index] <= dirty_in; // memory fill clears, cpu write sets
		end
	end

	// payload storage
	always_ff @(posedge clk) begin
		if (load) begin
			tag_q[index]  <= tag;
			line_q[index] <= line_in;
		end
	end

	// asynchronous read of the indexed set
	assign valid    = valid_q[index];
	assign dirty    = dirty_q[index];
	assign tag_out  = tag_q[index];
	assign line_out = line_q[index];

	// hit only on a valid set with matching tag
	assign hit = valid & (tag_out == tag);

endmodule : cache_way

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cache -f flist.f

output=$(./obj_dir/Vtb_cache 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
